//--- dnc_insert_locator.sv
//////////////////////////////////////////////////
// Insert position of a new key, combinational
// Only keys below count take part
// Result fits index_t while count < MAX_N
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dnc_insert_locator (
  input  dnc_sort_pkg::data_t  key,
  input  dnc_sort_pkg::data_t  keys [dnc_sort_pkg::MAX_N],
  input  dnc_sort_pkg::count_t count,
  output dnc_sort_pkg::index_t position
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Valid keys less than or equal to the new one
  dnc_sort_pkg::count_t num_le;

  //////////////////////////////////////////////////
  // Compare and count
  //////////////////////////////////////////////////

  // Equal keys count as smaller, so ties stay in arrival order
  always_comb begin
    num_le = '0;
    for (int i = 0; i < dnc_sort_pkg::MAX_N; i++) begin
      if ((dnc_sort_pkg::count_t'(i) < count) && (keys[i] <= key)) begin
        num_le = num_le + 1'b1;
      end
    end
  end

  // Store is sorted, so the count is the slot
  assign position = num_le[dnc_sort_pkg::INDEX_SIZE-1:0];

endmodule

//--- dnc_phi_emitter.sv
//////////////////////////////////////////////////
// Streams sorted indices, one per cycle
// No back-pressure on phi_out
// count must stay stable while streaming
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dnc_phi_emitter (
  input  logic                 CLK,
  input  logic                 RST,

  input  logic                 emit_start,
  input  dnc_sort_pkg::count_t count,
  input  dnc_sort_pkg::index_t indices [dnc_sort_pkg::MAX_N],

  output dnc_sort_pkg::index_t phi_out,
  output logic                 phi_out_enable,
  output logic                 emit_last
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  dnc_sort_pkg::count_t rd_ptr;
  dnc_sort_pkg::count_t cur_ptr;
  dnc_sort_pkg::count_t next_ptr;
  logic                 active;
  logic                 go;

  // Start restarts the read pointer at entry 0
  assign cur_ptr  = emit_start ? '0 : rd_ptr;
  assign next_ptr = dnc_sort_pkg::count_t'(cur_ptr + 1'b1);
  assign go       = (emit_start || active) && (cur_ptr < count);

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_ptr         <= '0;
      active         <= 1'b0;
      phi_out_enable <= 1'b0;
      emit_last      <= 1'b0;
    end else if (go) begin
      rd_ptr         <= next_ptr;
      active         <= (next_ptr < count);
      phi_out_enable <= 1'b1;
      // Flag rides with the final index
      emit_last      <= (next_ptr == count);
    end else begin
      active         <= 1'b0;
      phi_out_enable <= 1'b0;
      emit_last      <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge CLK) begin
    if (go) begin
      phi_out <= indices[cur_ptr[dnc_sort_pkg::INDEX_SIZE-1:0]];
    end
  end

endmodule

//--- dnc_sort_pkg.sv
//////////////////////////////////////////////////
// Shared sizes, controller states and types
// MAX_N must equal 2**INDEX_SIZE
// COUNT_SIZE must hold the value MAX_N itself
//////////////////////////////////////////////////

package dnc_sort_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Width of one usage value
  localparam int DATA_SIZE = 16;

  // Store depth, longest vector accepted
  localparam int MAX_N = 8;

  // Slot index width
  localparam int INDEX_SIZE = 3;

  // Element count width, 0 to MAX_N
  localparam int COUNT_SIZE = 4;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [DATA_SIZE-1:0] data_t;
  typedef logic [INDEX_SIZE-1:0] index_t;
  typedef logic [COUNT_SIZE-1:0] count_t;

  // Controller FSM states
  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    WAIT_U,
    EMIT,
    DONE
  } ctrl_state_t;

endpackage

//--- dnc_sort_store.sv
//////////////////////////////////////////////////
// Sorted register array with insert at a position
// Entry MAX_N-1 drops off on a shift
// Slots at or above count hold stale data
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dnc_sort_store #(
  parameter type payload_t = dnc_sort_pkg::data_t
) (
  input  logic                 CLK,
  input  logic                 RST,

  input  logic                 insert_en,
  input  dnc_sort_pkg::index_t insert_pos,
  input  payload_t             insert_value,

  output payload_t             entries [dnc_sort_pkg::MAX_N]
);

  //////////////////////////////////////////////////
  // Shift-insert
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // Known contents after reset
      for (int i = 0; i < dnc_sort_pkg::MAX_N; i++) begin
        entries[i] <= '0;
      end
    end else if (insert_en) begin
      // Slot 0 has nothing below to shift in
      if (insert_pos == '0) begin
        entries[0] <= insert_value;
      end
      // Above the position move up, below stay put
      for (int i = 1; i < dnc_sort_pkg::MAX_N; i++) begin
        if (dnc_sort_pkg::index_t'(i) == insert_pos) begin
          entries[i] <= insert_value;
        end else if (dnc_sort_pkg::index_t'(i) > insert_pos) begin
          entries[i] <= entries[i-1];
        end
      end
    end
  end

endmodule

//--- dnc_sort_tb.sv
//////////////////////////////////////////////////
// Directed testbench for the usage sorter
// Source answers after 0 to 3 cycles of LFSR delay
// Stops at the first mismatch
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dnc_sort_tb;

  //////////////////////////////////////////////////
  // Constants and signals
  //////////////////////////////////////////////////

  localparam int CLK_PERIOD = 100;
  localparam int MAX_DELAY = 3;
  // Reset check plus nine sort runs
  localparam int NUM_RUNS = 10;
  localparam int WATCHDOG_CYCLES =
    NUM_RUNS * (dnc_sort_pkg::MAX_N * (MAX_DELAY + 2) + 20);

  logic                 CLK = 1'b0;
  logic                 RST;
  logic                 start;
  logic                 ready;
  dnc_sort_pkg::count_t size_n_in;
  logic                 u_out_enable;
  logic                 u_in_enable;
  dnc_sort_pkg::data_t  u_in;
  dnc_sort_pkg::index_t phi_out;
  logic                 phi_out_enable;

  // Stimulus values and expected order
  dnc_sort_pkg::data_t  vals       [dnc_sort_pkg::MAX_N + 4];
  dnc_sort_pkg::data_t  saved_vals [dnc_sort_pkg::MAX_N];
  dnc_sort_pkg::index_t exp_phi    [dnc_sort_pkg::MAX_N];

  logic [15:0] lfsr_state = 16'd90;

  // Pulse counters, sampled on the rising edge
  int req_seen = 0;
  int phi_seen = 0;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  dnc_sort_top UUT (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ready          (ready),
    .size_n_in      (size_n_in),
    .u_out_enable   (u_out_enable),
    .u_in_enable    (u_in_enable),
    .u_in           (u_in),
    .phi_out        (phi_out),
    .phi_out_enable (phi_out_enable)
  );

  always @(posedge CLK) begin
    if (u_out_enable) begin
      req_seen = req_seen + 1;
    end
    if (phi_out_enable) begin
      phi_seen = phi_seen + 1;
    end
  end

  //////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////

  task stop_with_error(input string msg);
    dnc_sort_pkg::ctrl_state_t st;
    st = UUT.controller.state;
    $display("%s (FSM in %s)", msg, st.name());
    $display("sim failed");
    $fatal(1, "stopped at %0t ns", $time);
  endtask

  task check_index(input string name, input dnc_sort_pkg::index_t got,
                   input dnc_sort_pkg::index_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task check_count(input string name, input dnc_sort_pkg::count_t got,
                   input dnc_sort_pkg::count_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////

  // Taps 16 14 13 11, maximal length
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task draw_bits(input int nbits, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value      = {value[14:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task pick_delay(input bit random_delay, output int d);
    logic [15:0] bits;
    if (random_delay) begin
      draw_bits(2, bits);
      d = int'(bits[1:0]);
    end else begin
      d = 1;
    end
  endtask

  // Stable sort by rank, earlier arrival wins a tie
  task build_expected(input int n);
    int rank;
    for (int i = 0; i < n; i++) begin
      rank = 0;
      for (int j = 0; j < n; j++) begin
        if ((vals[j] < vals[i]) || ((vals[j] == vals[i]) && (j < i))) begin
          rank++;
        end
      end
      exp_phi[rank] = dnc_sort_pkg::index_t'(i);
    end
  endtask

  //////////////////////////////////////////////////
  // One sort run, from start to ready
  //////////////////////////////////////////////////

  task run_vector(input dnc_sort_pkg::count_t size, input bit random_delay,
                  input bit spurious);
    int n;
    int d;
    int req0;
    int phi0;
    n = (size > dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N)) ?
        dnc_sort_pkg::MAX_N : int'(size);
    build_expected(n);
    req0 = req_seen;
    phi0 = phi_seen;
    // Stray answer while idle
    if (spurious) begin
      u_in_enable = 1'b1;
      u_in        = '0;
      @(negedge CLK);
    end
    u_in_enable = 1'b0;
    start       = 1'b1;
    size_n_in   = size;
    @(negedge CLK);
    start = 1'b0;
    // Stray zero key before the first request, would sort first if taken
    if (spurious) begin
      u_in_enable = 1'b1;
      u_in        = '0;
    end
    if (n == 0) begin
      check_flag("ready", ready, 1'b1);
      @(negedge CLK);
      u_in_enable = 1'b0;
      check_flag("ready", ready, 1'b0);
      repeat (3) @(negedge CLK);
    end else begin
      @(negedge CLK);
      u_in_enable = 1'b0;
      for (int k = 0; k < n; k++) begin
        if (k == 0) begin
          while (!u_out_enable) @(negedge CLK);
        end else begin
          // Next request one cycle after the answer
          check_flag("u_out_enable", u_out_enable, 1'b1);
        end
        pick_delay(random_delay, d);
        repeat (d) begin
          @(negedge CLK);
          check_flag("u_out_enable", u_out_enable, 1'b0);
        end
        u_in_enable = 1'b1;
        u_in        = vals[k];
        @(negedge CLK);
        u_in_enable = 1'b0;
      end
      // emit_start cycle, stream begins next
      check_flag("phi_out_enable", phi_out_enable, 1'b0);
      check_flag("u_out_enable", u_out_enable, 1'b0);
      @(negedge CLK);
      for (int k = 0; k < n; k++) begin
        check_flag("phi_out_enable", phi_out_enable, 1'b1);
        check_index("phi_out", phi_out, exp_phi[k]);
        check_flag("ready", ready, 1'b0);
        @(negedge CLK);
      end
      check_flag("phi_out_enable", phi_out_enable, 1'b0);
      check_flag("ready", ready, 1'b1);
      @(negedge CLK);
      check_flag("ready", ready, 1'b0);
    end
    check_count("u_out_enable pulses", dnc_sort_pkg::count_t'(req_seen - req0),
                dnc_sort_pkg::count_t'(n));
    check_count("phi_out_enable cycles", dnc_sort_pkg::count_t'(phi_seen - phi0),
                dnc_sort_pkg::count_t'(n));
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task idle_after_reset();
    repeat (3) begin
      check_flag("ready", ready, 1'b0);
      check_flag("u_out_enable", u_out_enable, 1'b0);
      check_flag("phi_out_enable", phi_out_enable, 1'b0);
      @(negedge CLK);
    end
  endtask

  task distinct_values();
    logic [15:0] v;
    bit          dup;
    for (int i = 0; i < dnc_sort_pkg::MAX_N; i++) begin
      // Redraw until unlike every earlier value
      do begin
        draw_bits(16, v);
        dup = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (vals[j] == v) begin
            dup = 1'b1;
          end
        end
      end while (dup);
      vals[i]       = v;
      saved_vals[i] = v;
    end
    run_vector(dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N), 1'b0, 1'b0);
  endtask

  task tied_values();
    vals[0] = 16'h0005;
    vals[1] = 16'h0003;
    vals[2] = 16'h0005;
    vals[3] = 16'h0001;
    vals[4] = 16'h0003;
    vals[5] = 16'h0005;
    vals[6] = 16'h0010;
    vals[7] = 16'h0001;
    run_vector(dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N), 1'b0, 1'b0);
    // All equal, so phi is plain arrival order
    for (int i = 0; i < dnc_sort_pkg::MAX_N; i++) begin
      vals[i] = 16'h1234;
    end
    run_vector(dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N), 1'b0, 1'b0);
  endtask

  task random_delays();
    for (int i = 0; i < dnc_sort_pkg::MAX_N; i++) begin
      vals[i] = saved_vals[i];
    end
    run_vector(dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N), 1'b1, 1'b1);
  endtask

  task size_limits();
    logic [15:0] v;
    draw_bits(16, v);
    vals[0] = v;
    run_vector(dnc_sort_pkg::count_t'(1), 1'b0, 1'b0);
    run_vector(dnc_sort_pkg::count_t'(0), 1'b0, 1'b0);
    // Extra values beyond MAX_N must never be asked for
    for (int i = 0; i < dnc_sort_pkg::MAX_N + 4; i++) begin
      draw_bits(16, v);
      vals[i] = v;
    end
    run_vector(dnc_sort_pkg::count_t'(12), 1'b1, 1'b0);
  endtask

  task back_to_back();
    for (int i = 0; i < dnc_sort_pkg::MAX_N; i++) begin
      vals[i] = dnc_sort_pkg::data_t'(80 - 10 * i);
    end
    run_vector(dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N), 1'b0, 1'b0);
    // Second vector starts right after ready
    vals[0] = 16'h0003;
    vals[1] = 16'h0001;
    vals[2] = 16'h0004;
    vals[3] = 16'h0001;
    vals[4] = 16'h0005;
    run_vector(dnc_sort_pkg::count_t'(5), 1'b1, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    RST         = 1'b1;
    start       = 1'b0;
    size_n_in   = '0;
    u_in_enable = 1'b0;
    u_in        = '0;
    repeat (2) @(negedge CLK);
    RST = 1'b0;
    idle_after_reset();
    distinct_values();
    tied_values();
    random_delays();
    size_limits();
    back_to_back();
    $display("sim passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_error($sformatf("Timeout, tests still running after %0d cycles",
                              WATCHDOG_CYCLES));
  end

endmodule

//--- dnc_sort_top.sv
//////////////////////////////////////////////////
// Usage sorter, returns allocation order phi
// One vector in flight, sizes clamped to MAX_N
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dnc_sort_top (
  input  logic                 CLK,
  input  logic                 RST,

  // Control handshake
  input  logic                 start,
  output logic                 ready,
  input  dnc_sort_pkg::count_t size_n_in,

  // Usage request and answer
  output logic                 u_out_enable,
  input  logic                 u_in_enable,
  input  dnc_sort_pkg::data_t  u_in,

  // Allocation order stream
  output dnc_sort_pkg::index_t phi_out,
  output logic                 phi_out_enable
);

  //////////////////////////////////////////////////
  // Wires
  //////////////////////////////////////////////////

  logic                 insert_en;
  logic                 emit_start;
  logic                 emit_last;
  dnc_sort_pkg::count_t count;
  dnc_sort_pkg::index_t insert_pos;
  dnc_sort_pkg::index_t new_index;

  dnc_sort_pkg::data_t  key_entries   [dnc_sort_pkg::MAX_N];
  dnc_sort_pkg::index_t index_entries [dnc_sort_pkg::MAX_N];

  // Slot index is the arrival number, always below MAX_N on insert
  assign new_index = count[dnc_sort_pkg::INDEX_SIZE-1:0];

  //////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////

  dnc_sort_vector controller (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size_n_in    (size_n_in),
    .u_in_enable  (u_in_enable),
    .ready        (ready),
    .u_out_enable (u_out_enable),
    .insert_en    (insert_en),
    .count        (count),
    .emit_start   (emit_start),
    .emit_last    (emit_last)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  dnc_insert_locator locator (
    .key      (u_in),
    .keys     (key_entries),
    .count    (count),
    .position (insert_pos)
  );

  // Usage keys
  dnc_sort_store #(
    .payload_t (dnc_sort_pkg::data_t)
  ) key_store (
    .CLK          (CLK),
    .RST          (RST),
    .insert_en    (insert_en),
    .insert_pos   (insert_pos),
    .insert_value (u_in),
    .entries      (key_entries)
  );

  // Slot indices, moved in step with the keys
  dnc_sort_store #(
    .payload_t (dnc_sort_pkg::index_t)
  ) index_store (
    .CLK          (CLK),
    .RST          (RST),
    .insert_en    (insert_en),
    .insert_pos   (insert_pos),
    .insert_value (new_index),
    .entries      (index_entries)
  );

  dnc_phi_emitter emitter (
    .CLK            (CLK),
    .RST            (RST),
    .emit_start     (emit_start),
    .count          (count),
    .indices        (index_entries),
    .phi_out        (phi_out),
    .phi_out_enable (phi_out_enable),
    .emit_last      (emit_last)
  );

endmodule

//--- dnc_sort_vector.sv
//////////////////////////////////////////////////
// Control FSM for one usage vector at a time
// Sizes above MAX_N are clamped on start
// Start is only taken in IDLE
//////////////////////////////////////////////////

`timescale 1ns/100ps

module dnc_sort_vector (
  input  logic                 CLK,
  input  logic                 RST,

  // Handshake
  input  logic                 start,
  input  dnc_sort_pkg::count_t size_n_in,
  input  logic                 u_in_enable,
  output logic                 ready,
  output logic                 u_out_enable,

  // Datapath control
  output logic                 insert_en,
  output dnc_sort_pkg::count_t count,
  output logic                 emit_start,
  input  logic                 emit_last
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  dnc_sort_pkg::ctrl_state_t state;

  // Target size held for the whole run
  dnc_sort_pkg::count_t size_target;
  dnc_sort_pkg::count_t size_clamped;

  // Accepted answer completes the vector
  logic last_insert;

  //////////////////////////////////////////////////
  // Combinational
  //////////////////////////////////////////////////

  // Clamp requested size to store depth
  assign size_clamped = (size_n_in > dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N)) ?
                        dnc_sort_pkg::count_t'(dnc_sort_pkg::MAX_N) : size_n_in;

  // Answers count only while a request is outstanding
  assign insert_en = (state == dnc_sort_pkg::WAIT_U) && u_in_enable;

  assign last_insert = insert_en &&
                       (dnc_sort_pkg::count_t'(count + 1'b1) == size_target);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= dnc_sort_pkg::IDLE;
      size_target  <= '0;
      count        <= '0;
      ready        <= 1'b0;
      u_out_enable <= 1'b0;
      emit_start   <= 1'b0;
    end else begin
      // Strobes are single-cycle unless set below
      ready        <= 1'b0;
      u_out_enable <= 1'b0;
      emit_start   <= 1'b0;

      case (state)
        dnc_sort_pkg::IDLE: begin
          if (start) begin
            size_target <= size_clamped;
            // New run, forget the old vector
            count       <= '0;
            if (size_clamped == '0) begin
              // Empty vector finishes at once
              ready <= 1'b1;
              state <= dnc_sort_pkg::DONE;
            end else begin
              state <= dnc_sort_pkg::REQUEST;
            end
          end
        end

        dnc_sort_pkg::REQUEST: begin
          // First request, high during first WAIT_U cycle
          u_out_enable <= 1'b1;
          state        <= dnc_sort_pkg::WAIT_U;
        end

        dnc_sort_pkg::WAIT_U: begin
          if (insert_en) begin
            count <= count + 1'b1;
            if (last_insert) begin
              emit_start <= 1'b1;
              state      <= dnc_sort_pkg::EMIT;
            end else begin
              // Next request on the following cycle
              u_out_enable <= 1'b1;
            end
          end
        end

        dnc_sort_pkg::EMIT: begin
          // Ready one cycle after the final index
          if (emit_last) begin
            ready <= 1'b1;
            state <= dnc_sort_pkg::DONE;
          end
        end

        dnc_sort_pkg::DONE: begin
          state <= dnc_sort_pkg::IDLE;
        end

        default: begin
          state <= dnc_sort_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the usage sorter testbench with Verilator
# Exit status 0 on pass, 1 on any failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module dnc_sort_tb -o dnc_sort_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Build failed with status $build_status"
  exit 1
fi

./obj_dir/dnc_sort_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "FAIL: testbench reported an error"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "FAIL: simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "FAIL: simulation ended without a result"
  exit 1
fi

echo "PASS"
exit 0

//--- src.f
dnc_sort_pkg.sv
dnc_sort_store.sv
dnc_insert_locator.sv
dnc_phi_emitter.sv
dnc_sort_vector.sv
dnc_sort_top.sv
dnc_sort_tb.sv
